//--- render_pkg.sv
package render_pkg;

    // scan and sprite geometry
    localparam int MAP_H_WIDTH     = 10;
    localparam int MAP_V_WIDTH     = 10;
    localparam int PIX_INDEX_WIDTH = MAP_H_WIDTH + MAP_V_WIDTH;

    localparam int PLAYER_SIZE       = 16;
    localparam int BULLET_SIZE       = 4;
    localparam int PLAYER_MASK_WIDTH = PLAYER_SIZE * PLAYER_SIZE;
    localparam int BULLET_MASK_WIDTH = BULLET_SIZE * BULLET_SIZE;

    // map kept at 1/8 resolution, 80 x 60 tiles
    localparam int MAP_TILE_SHIFT = 3;
    localparam int MAP_TILES_H    = 80;

    localparam int SRAM_DATA_WIDTH = 16;
    localparam int SRAM_ADDR_WIDTH = 20;

    localparam int COLOR_WIDTH   = 4;
    localparam int RGB_WIDTH     = 24;
    localparam int PALETTE_DEPTH = 1 << COLOR_WIDTH;

    // four colour indices per sram word
    localparam int PIX_PER_WORD_SHIFT = $clog2(SRAM_DATA_WIDTH / COLOR_WIDTH);

    // five objects, so three bits
    typedef enum logic [2:0] {
        OBJ_MAP     = 3'd0,
        OBJ_PLAYER1 = 3'd1,
        OBJ_PLAYER2 = 3'd2,
        OBJ_BULLET1 = 3'd3,
        OBJ_BULLET2 = 3'd4
    } object_id_e;

    // word bases of each sprite
    localparam logic [SRAM_ADDR_WIDTH-1:0] MAP_BASE     = 20'h01000; // 1200 words
    localparam logic [SRAM_ADDR_WIDTH-1:0] PLAYER1_BASE = 20'h02000; // 64 words each
    localparam logic [SRAM_ADDR_WIDTH-1:0] PLAYER2_BASE = 20'h02040;
    localparam logic [SRAM_ADDR_WIDTH-1:0] BULLET1_BASE = 20'h02080; // 4 words each
    localparam logic [SRAM_ADDR_WIDTH-1:0] BULLET2_BASE = 20'h02084;

endpackage

//--- pixel_decoder.sv
`timescale 1ns/100ps

module pixel_decoder (
    input  logic signed [render_pkg::MAP_H_WIDTH-1:0]       i_player1_x,
    input  logic signed [render_pkg::MAP_V_WIDTH-1:0]       i_player1_y,
    input  logic [render_pkg::PLAYER_MASK_WIDTH-1:0]        i_player1_opacity_mask,
    input  logic signed [render_pkg::MAP_H_WIDTH-1:0]       i_player2_x,
    input  logic signed [render_pkg::MAP_V_WIDTH-1:0]       i_player2_y,
    input  logic [render_pkg::PLAYER_MASK_WIDTH-1:0]        i_player2_opacity_mask,
    input  logic signed [render_pkg::MAP_H_WIDTH-1:0]       i_bullet1_x,
    input  logic signed [render_pkg::MAP_V_WIDTH-1:0]       i_bullet1_y,
    input  logic                                            i_bullet1_valid,
    input  logic [render_pkg::BULLET_MASK_WIDTH-1:0]        i_bullet1_opacity_mask,
    input  logic signed [render_pkg::MAP_H_WIDTH-1:0]       i_bullet2_x,
    input  logic signed [render_pkg::MAP_V_WIDTH-1:0]       i_bullet2_y,
    input  logic                                            i_bullet2_valid,
    input  logic [render_pkg::BULLET_MASK_WIDTH-1:0]        i_bullet2_opacity_mask,
    input  logic [render_pkg::MAP_H_WIDTH-1:0]              i_vga_h,
    input  logic [render_pkg::MAP_V_WIDTH-1:0]              i_vga_v,
    input  logic                                            i_is_gaming,
    output render_pkg::object_id_e                          o_object_id,
    output logic [render_pkg::PIX_INDEX_WIDTH-1:0]          o_pixel_index
);
    import render_pkg::*;

    // two spare bits so scan minus signed position never wraps
    localparam int DW = ((MAP_H_WIDTH > MAP_V_WIDTH) ? MAP_H_WIDTH : MAP_V_WIDTH) + 2;
    localparam int MASK_IDX_W = $clog2(PLAYER_MASK_WIDTH);

    logic signed [DW-1:0]       h_ext;
    logic signed [DW-1:0]       v_ext;
    logic [PIX_INDEX_WIDTH-1:0] map_index;
    logic [PIX_INDEX_WIDTH-1:0] p1_off, p2_off, b1_off, b2_off;
    logic                       p1_hit, p2_hit, b1_hit, b2_hit;

    // square sprite test with offset row * size + col
    function automatic logic sprite_hit(
        input  logic signed [DW-1:0]       dx,
        input  logic signed [DW-1:0]       dy,
        input  int                         size,
        input  logic [PLAYER_MASK_WIDTH-1:0] mask,
        output logic [PIX_INDEX_WIDTH-1:0] offset
    );
        logic in_box;
        in_box = (dx >= 0) && (dy >= 0) && (dx < DW'(size)) && (dy < DW'(size));
        offset = PIX_INDEX_WIDTH'(dy * size + dx);
        return in_box && mask[offset[MASK_IDX_W-1:0]];
    endfunction

    assign h_ext = DW'(i_vga_h);
    assign v_ext = DW'(i_vga_v);

    assign map_index = PIX_INDEX_WIDTH'((i_vga_v >> MAP_TILE_SHIFT) * MAP_TILES_H)
                     + PIX_INDEX_WIDTH'(i_vga_h >> MAP_TILE_SHIFT);

    always_comb begin
        p1_hit = sprite_hit(h_ext - DW'(i_player1_x), v_ext - DW'(i_player1_y),
                            PLAYER_SIZE, i_player1_opacity_mask, p1_off);
        p2_hit = sprite_hit(h_ext - DW'(i_player2_x), v_ext - DW'(i_player2_y),
                            PLAYER_SIZE, i_player2_opacity_mask, p2_off);
        b1_hit = sprite_hit(h_ext - DW'(i_bullet1_x), v_ext - DW'(i_bullet1_y),
                            BULLET_SIZE, PLAYER_MASK_WIDTH'(i_bullet1_opacity_mask), b1_off);
        b2_hit = sprite_hit(h_ext - DW'(i_bullet2_x), v_ext - DW'(i_bullet2_y),
                            BULLET_SIZE, PLAYER_MASK_WIDTH'(i_bullet2_opacity_mask), b2_off);

        o_object_id   = OBJ_MAP; // map fallback also when not gaming
        o_pixel_index = map_index;
        if (i_is_gaming) begin
            if (i_bullet1_valid && b1_hit) begin
                o_object_id   = OBJ_BULLET1;
                o_pixel_index = b1_off;
            end else if (i_bullet2_valid && b2_hit) begin
                o_object_id   = OBJ_BULLET2;
                o_pixel_index = b2_off;
            end else if (p1_hit) begin
                o_object_id   = OBJ_PLAYER1;
                o_pixel_index = p1_off;
            end else if (p2_hit) begin
                o_object_id   = OBJ_PLAYER2;
                o_pixel_index = p2_off;
            end
        end
    end

endmodule

//--- sram_addr_encoder.sv
`timescale 1ns/100ps

module sram_addr_encoder (
    input  logic                                    i_clk,
    input  logic                                    i_rst_n,
    input  render_pkg::object_id_e                  i_object_id,
    input  logic [render_pkg::PIX_INDEX_WIDTH-1:0]  i_pixel_index,
    output logic [render_pkg::SRAM_ADDR_WIDTH-1:0]  o_sram_addr
);
    import render_pkg::*;

    logic [SRAM_ADDR_WIDTH-1:0] base;
    logic [SRAM_ADDR_WIDTH-1:0] next_addr;

    always_comb begin
        case (i_object_id)
            OBJ_PLAYER1: base = PLAYER1_BASE;
            OBJ_PLAYER2: base = PLAYER2_BASE;
            OBJ_BULLET1: base = BULLET1_BASE;
            OBJ_BULLET2: base = BULLET2_BASE;
            default:     base = MAP_BASE;
        endcase
    end

    // word offset, several pixels share a word
    assign next_addr = base + SRAM_ADDR_WIDTH'(i_pixel_index >> PIX_PER_WORD_SHIFT);

    // stage 1 of the address path
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_sram_addr <= MAP_BASE;
        end else begin
            o_sram_addr <= next_addr;
        end
    end

endmodule

//--- sram_data_decoder.sv
`timescale 1ns/100ps

module sram_data_decoder (
    input  logic [render_pkg::PIX_INDEX_WIDTH-1:0]  i_pixel_index,  // stage 2
    input  logic [render_pkg::SRAM_DATA_WIDTH-1:0]  i_sram_data,
    output logic [render_pkg::COLOR_WIDTH-1:0]      o_color_index
);
    import render_pkg::*;

    logic [PIX_PER_WORD_SHIFT-1:0] nibble_sel;

    // nibble 0 sits in the low bits
    assign nibble_sel = i_pixel_index[PIX_PER_WORD_SHIFT-1:0];

    always_comb begin
        o_color_index = '0;
        for (int i = 0; i < (1 << PIX_PER_WORD_SHIFT); i++) begin
            if (nibble_sel == PIX_PER_WORD_SHIFT'(i)) begin
                o_color_index = i_sram_data[i*COLOR_WIDTH +: COLOR_WIDTH];
            end
        end
    end

endmodule

//--- palette_regs.sv
`timescale 1ns/100ps

module palette_regs (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_pal_we,
    input  logic [render_pkg::COLOR_WIDTH-1:0]  i_pal_addr,
    input  logic [render_pkg::RGB_WIDTH-1:0]    i_pal_data,
    input  logic [render_pkg::COLOR_WIDTH-1:0]  i_rd_index,
    output logic [render_pkg::RGB_WIDTH-1:0]    o_rd_rgb
);
    import render_pkg::*;

    logic [RGB_WIDTH-1:0] entries [PALETTE_DEPTH];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < PALETTE_DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (i_pal_we) begin
            entries[i_pal_addr] <= i_pal_data;
        end
    end

    // read is combinational, new value visible right after the write edge
    assign o_rd_rgb = entries[i_rd_index];

endmodule

//--- color_decoder.sv
`timescale 1ns/100ps

module color_decoder #(
    parameter logic [render_pkg::RGB_WIDTH-1:0] SHIELD_TINT = 24'h0000FF
) (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_pal_we,
    input  logic [render_pkg::COLOR_WIDTH-1:0]  i_pal_addr,
    input  logic [render_pkg::RGB_WIDTH-1:0]    i_pal_data,
    input  render_pkg::object_id_e              i_object_id,    // stage 2
    input  logic                                i_shield,       // stage 2
    input  logic [render_pkg::COLOR_WIDTH-1:0]  i_color_index,
    output logic [render_pkg::RGB_WIDTH-1:0]    o_rgb
);
    import render_pkg::*;

    logic [RGB_WIDTH-1:0] pal_rgb;
    logic                 is_player;

    palette_regs u_palette_regs (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_pal_we   (i_pal_we),
        .i_pal_addr (i_pal_addr),
        .i_pal_data (i_pal_data),
        .i_rd_index (i_color_index),
        .o_rd_rgb   (pal_rgb)
    );

    assign is_player = (i_object_id == OBJ_PLAYER1) || (i_object_id == OBJ_PLAYER2);

    // tint only players, a bullet on top keeps its own colour
    assign o_rgb = (is_player && i_shield) ? (pal_rgb | SHIELD_TINT) : pal_rgb;

endmodule

//--- frame_decoder.sv
`timescale 1ns/100ps

module frame_decoder #(
    parameter logic [render_pkg::RGB_WIDTH-1:0] SHIELD_TINT = 24'h0000FF
) (
    input  logic                                            i_clk,
    input  logic                                            i_rst_n,
    input  logic signed [render_pkg::MAP_H_WIDTH-1:0]       i_player1_x,
    input  logic signed [render_pkg::MAP_V_WIDTH-1:0]       i_player1_y,
    input  logic                                            i_player1_shield,
    input  logic [render_pkg::PLAYER_MASK_WIDTH-1:0]        i_player1_opacity_mask,
    input  logic signed [render_pkg::MAP_H_WIDTH-1:0]       i_player2_x,
    input  logic signed [render_pkg::MAP_V_WIDTH-1:0]       i_player2_y,
    input  logic                                            i_player2_shield,
    input  logic [render_pkg::PLAYER_MASK_WIDTH-1:0]        i_player2_opacity_mask,
    input  logic signed [render_pkg::MAP_H_WIDTH-1:0]       i_bullet1_x,
    input  logic signed [render_pkg::MAP_V_WIDTH-1:0]       i_bullet1_y,
    input  logic                                            i_bullet1_valid,
    input  logic [render_pkg::BULLET_MASK_WIDTH-1:0]        i_bullet1_opacity_mask,
    input  logic signed [render_pkg::MAP_H_WIDTH-1:0]       i_bullet2_x,
    input  logic signed [render_pkg::MAP_V_WIDTH-1:0]       i_bullet2_y,
    input  logic                                            i_bullet2_valid,
    input  logic [render_pkg::BULLET_MASK_WIDTH-1:0]        i_bullet2_opacity_mask,
    input  logic [render_pkg::MAP_H_WIDTH-1:0]              i_vga_h,
    input  logic [render_pkg::MAP_V_WIDTH-1:0]              i_vga_v,
    input  logic                                            i_is_gaming,
    output logic [render_pkg::SRAM_ADDR_WIDTH-1:0]          o_sram_addr,
    input  logic [render_pkg::SRAM_DATA_WIDTH-1:0]          i_sram_data,
    input  logic                                            i_pal_we,
    input  logic [render_pkg::COLOR_WIDTH-1:0]              i_pal_addr,
    input  logic [render_pkg::RGB_WIDTH-1:0]                i_pal_data,
    output logic [render_pkg::RGB_WIDTH-1:0]                o_rgb
);
    import render_pkg::*;

    object_id_e                 object_id_s0, object_id_s1, object_id_s2;
    logic [PIX_INDEX_WIDTH-1:0] pixel_index_s0, pixel_index_s1, pixel_index_s2;
    logic                       shield_s0, shield_s1, shield_s2;
    logic [COLOR_WIDTH-1:0]     color_index;

    pixel_decoder u_pixel_decoder (
        .i_player1_x            (i_player1_x),
        .i_player1_y            (i_player1_y),
        .i_player1_opacity_mask (i_player1_opacity_mask),
        .i_player2_x            (i_player2_x),
        .i_player2_y            (i_player2_y),
        .i_player2_opacity_mask (i_player2_opacity_mask),
        .i_bullet1_x            (i_bullet1_x),
        .i_bullet1_y            (i_bullet1_y),
        .i_bullet1_valid        (i_bullet1_valid),
        .i_bullet1_opacity_mask (i_bullet1_opacity_mask),
        .i_bullet2_x            (i_bullet2_x),
        .i_bullet2_y            (i_bullet2_y),
        .i_bullet2_valid        (i_bullet2_valid),
        .i_bullet2_opacity_mask (i_bullet2_opacity_mask),
        .i_vga_h                (i_vga_h),
        .i_vga_v                (i_vga_v),
        .i_is_gaming            (i_is_gaming),
        .o_object_id            (object_id_s0),
        .o_pixel_index          (pixel_index_s0)
    );

    sram_addr_encoder u_sram_addr_encoder (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_object_id   (object_id_s0),
        .i_pixel_index (pixel_index_s0),
        .o_sram_addr   (o_sram_addr)
    );

    sram_data_decoder u_sram_data_decoder (
        .i_pixel_index (pixel_index_s2),
        .i_sram_data   (i_sram_data),
        .o_color_index (color_index)
    );

    color_decoder #(
        .SHIELD_TINT (SHIELD_TINT)
    ) u_color_decoder (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_pal_we      (i_pal_we),
        .i_pal_addr    (i_pal_addr),
        .i_pal_data    (i_pal_data),
        .i_object_id   (object_id_s2),
        .i_shield      (shield_s2),
        .i_color_index (color_index),
        .o_rgb         (o_rgb)
    );

    // shield of whichever player won this pixel
    always_comb begin
        case (object_id_s0)
            OBJ_PLAYER1: shield_s0 = i_player1_shield;
            OBJ_PLAYER2: shield_s0 = i_player2_shield;
            default:     shield_s0 = 1'b0;
        endcase
    end

    // s1 runs beside the sram address, s2 beside the returned word
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            object_id_s1   <= OBJ_MAP;
            object_id_s2   <= OBJ_MAP;
            pixel_index_s1 <= '0;
            pixel_index_s2 <= '0;
            shield_s1      <= 1'b0;
            shield_s2      <= 1'b0;
        end else begin
            object_id_s1   <= object_id_s0;
            object_id_s2   <= object_id_s1;
            pixel_index_s1 <= pixel_index_s0;
            pixel_index_s2 <= pixel_index_s1;
            shield_s1      <= shield_s0;
            shield_s2      <= shield_s1;
        end
    end

endmodule

//--- frame_decoder_sva.sv
`timescale 1ns/100ps

module frame_decoder_sva (
    input  logic                                    i_clk,
    input  logic                                    i_rst_n,
    input  logic [render_pkg::SRAM_ADDR_WIDTH-1:0]  i_sram_addr,
    input  render_pkg::object_id_e                  i_object_id_s1,
    input  logic [render_pkg::PIX_INDEX_WIDTH-1:0]  i_pixel_index_s1,
    input  logic                                    i_pal_we,
    input  logic [render_pkg::COLOR_WIDTH-1:0]      i_pal_addr,
    input  logic [render_pkg::RGB_WIDTH-1:0]        i_pal_data,
    input  logic [render_pkg::RGB_WIDTH-1:0]        i_pal_entries [render_pkg::PALETTE_DEPTH]
);
    import render_pkg::*;

    function automatic logic [SRAM_ADDR_WIDTH-1:0] word_addr(input object_id_e id,
                                                            input logic [PIX_INDEX_WIDTH-1:0] idx);
        case (id)
            OBJ_PLAYER1: return PLAYER1_BASE + SRAM_ADDR_WIDTH'(idx >> 2);
            OBJ_PLAYER2: return PLAYER2_BASE + SRAM_ADDR_WIDTH'(idx >> 2);
            OBJ_BULLET1: return BULLET1_BASE + SRAM_ADDR_WIDTH'(idx >> 2);
            OBJ_BULLET2: return BULLET2_BASE + SRAM_ADDR_WIDTH'(idx >> 2);
            default:     return MAP_BASE + SRAM_ADDR_WIDTH'(idx >> 2);
        endcase
    endfunction

    a_reset_addr: assert property (@(posedge i_clk) !i_rst_n |-> i_sram_addr == MAP_BASE)
        else $error("sram address not at map base during reset");

    // address register and stage-1 delay load on the same edge
    a_addr_from_s1: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_sram_addr == word_addr(i_object_id_s1, i_pixel_index_s1))
        else $error("sram address does not match the stage-1 pixel");

    for (genvar i = 0; i < PALETTE_DEPTH; i++) begin : g_pal
        a_pal_hit: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            (i_pal_we && i_pal_addr == COLOR_WIDTH'(i)) |=> i_pal_entries[i] == $past(i_pal_data))
            else $error("palette entry %0d not written", i);
        a_pal_other: assert property (@(posedge i_clk) disable iff (!i_rst_n)
            (i_pal_we && i_pal_addr != COLOR_WIDTH'(i)) |=> $stable(i_pal_entries[i]))
            else $error("palette entry %0d changed by a write elsewhere", i);
    end

endmodule

bind frame_decoder frame_decoder_sva u_frame_decoder_sva (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_sram_addr      (o_sram_addr),
    .i_object_id_s1   (object_id_s1),
    .i_pixel_index_s1 (pixel_index_s1),
    .i_pal_we         (i_pal_we),
    .i_pal_addr       (i_pal_addr),
    .i_pal_data       (i_pal_data),
    .i_pal_entries    (u_color_decoder.u_palette_regs.entries)
);

//--- tb_frame_decoder.sv
`timescale 1ns/100ps

module tb_frame_decoder;
    import render_pkg::*;

    localparam int          CLK_PERIOD   = 8;
    localparam logic [31:0] SEED         = 32'h12767ad0;
    localparam int          SRAM_LATENCY = 1;   // registered read in the model below
    localparam int          SRAM_DEPTH   = 16384;
    localparam logic [RGB_WIDTH-1:0] TB_TINT = 24'h2000C0;
    localparam int          NUM_TESTS    = 6;
    localparam int          PIX_PER_TEST = 800;
    localparam longint      WATCHDOG_NS  = NUM_TESTS * PIX_PER_TEST * CLK_PERIOD + 4000;

    logic i_clk, i_rst_n;
    logic signed [MAP_H_WIDTH-1:0] i_player1_x, i_player2_x, i_bullet1_x, i_bullet2_x;
    logic signed [MAP_V_WIDTH-1:0] i_player1_y, i_player2_y, i_bullet1_y, i_bullet2_y;
    logic i_player1_shield, i_player2_shield, i_bullet1_valid, i_bullet2_valid;
    logic [PLAYER_MASK_WIDTH-1:0] i_player1_opacity_mask, i_player2_opacity_mask;
    logic [BULLET_MASK_WIDTH-1:0] i_bullet1_opacity_mask, i_bullet2_opacity_mask;
    logic [MAP_H_WIDTH-1:0]     i_vga_h;
    logic [MAP_V_WIDTH-1:0]     i_vga_v;
    logic                       i_is_gaming;
    logic [SRAM_ADDR_WIDTH-1:0] o_sram_addr;
    logic [SRAM_DATA_WIDTH-1:0] sram_data;
    logic                       i_pal_we;
    logic [COLOR_WIDTH-1:0]     i_pal_addr;
    logic [RGB_WIDTH-1:0]       i_pal_data;
    logic [RGB_WIDTH-1:0]       o_rgb;

    logic [SRAM_DATA_WIDTH-1:0] sram_mem [SRAM_DEPTH];
    logic [RGB_WIDTH-1:0]       pal_model [PALETTE_DEPTH];
    logic [31:0]                rng_state;
    int                         error_count;

    // expected values one and two cycles behind the scan position
    bit                         chk1, chk2;
    logic [SRAM_ADDR_WIDTH-1:0] exp_addr1;
    logic [RGB_WIDTH-1:0]       exp_rgb1, exp_rgb2;

    frame_decoder #(
        .SHIELD_TINT (TB_TINT)
    ) i_dut (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_player1_x (i_player1_x), .i_player1_y (i_player1_y),
        .i_player1_shield (i_player1_shield), .i_player1_opacity_mask (i_player1_opacity_mask),
        .i_player2_x (i_player2_x), .i_player2_y (i_player2_y),
        .i_player2_shield (i_player2_shield), .i_player2_opacity_mask (i_player2_opacity_mask),
        .i_bullet1_x (i_bullet1_x), .i_bullet1_y (i_bullet1_y),
        .i_bullet1_valid (i_bullet1_valid), .i_bullet1_opacity_mask (i_bullet1_opacity_mask),
        .i_bullet2_x (i_bullet2_x), .i_bullet2_y (i_bullet2_y),
        .i_bullet2_valid (i_bullet2_valid), .i_bullet2_opacity_mask (i_bullet2_opacity_mask),
        .i_vga_h (i_vga_h), .i_vga_v (i_vga_v), .i_is_gaming (i_is_gaming),
        .o_sram_addr (o_sram_addr), .i_sram_data (sram_data),
        .i_pal_we (i_pal_we), .i_pal_addr (i_pal_addr), .i_pal_data (i_pal_data),
        .o_rgb (o_rgb)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    always @(posedge i_clk) sram_data <= sram_mem[o_sram_addr[13:0]]; // sram model

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [SRAM_ADDR_WIDTH-1:0] base_of(input object_id_e id);
        case (id)
            OBJ_PLAYER1: return PLAYER1_BASE;
            OBJ_PLAYER2: return PLAYER2_BASE;
            OBJ_BULLET1: return BULLET1_BASE;
            OBJ_BULLET2: return BULLET2_BASE;
            default:     return MAP_BASE;
        endcase
    endfunction

    function automatic bit hit_test(input int dx, input int dy, input int size,
                                    input logic [PLAYER_MASK_WIDTH-1:0] mask, output int off);
        off = dy * size + dx;
        if (dx < 0 || dy < 0 || dx >= size || dy >= size)
            return 1'b0;
        return mask[off] == 1'b1;
    endfunction

    // reference for hit, priority, address, nibble and colour rules
    function automatic void predict(input int h, input int v,
                                    output logic [SRAM_ADDR_WIDTH-1:0] addr,
                                    output logic [RGB_WIDTH-1:0] rgb);
        object_id_e                 id;
        int                         idx, off;
        bit                         sh;
        logic [SRAM_DATA_WIDTH-1:0] word;
        id  = OBJ_MAP;
        idx = (v >> MAP_TILE_SHIFT) * 80 + (h >> MAP_TILE_SHIFT);
        sh  = 1'b0;
        if (i_is_gaming) begin
            if (i_bullet1_valid && hit_test(h - int'(i_bullet1_x), v - int'(i_bullet1_y),
                    BULLET_SIZE, PLAYER_MASK_WIDTH'(i_bullet1_opacity_mask), off)) begin
                id  = OBJ_BULLET1;
                idx = off;
            end else if (i_bullet2_valid && hit_test(h - int'(i_bullet2_x),
                    v - int'(i_bullet2_y), BULLET_SIZE,
                    PLAYER_MASK_WIDTH'(i_bullet2_opacity_mask), off)) begin
                id  = OBJ_BULLET2;
                idx = off;
            end else if (hit_test(h - int'(i_player1_x), v - int'(i_player1_y),
                    PLAYER_SIZE, i_player1_opacity_mask, off)) begin
                id  = OBJ_PLAYER1;
                idx = off;
                sh  = i_player1_shield;
            end else if (hit_test(h - int'(i_player2_x), v - int'(i_player2_y),
                    PLAYER_SIZE, i_player2_opacity_mask, off)) begin
                id  = OBJ_PLAYER2;
                idx = off;
                sh  = i_player2_shield;
            end
        end
        addr = base_of(id) + SRAM_ADDR_WIDTH'(idx / 4);
        word = sram_mem[addr[13:0]];
        rgb  = pal_model[word[(idx % 4) * 4 +: 4]];
        if (sh) rgb = rgb | TB_TINT;
    endfunction

    task automatic check_rgb(input string name, input logic [RGB_WIDTH-1:0] exp_val,
                             input logic [RGB_WIDTH-1:0] act_val);
        if (act_val !== exp_val) begin
            error_count++;
            $display("ERROR t=%0t %s expected %h got %h", $time, name, exp_val, act_val);
        end
    endtask

    task automatic check_addr(input string name, input logic [SRAM_ADDR_WIDTH-1:0] exp_val,
                              input logic [SRAM_ADDR_WIDTH-1:0] act_val);
        if (act_val !== exp_val) begin
            error_count++;
            $display("ERROR t=%0t %s expected %h got %h", $time, name, exp_val, act_val);
        end
    endtask

    // check older pixels and then present a new one
    task automatic scan_pixel(input int h, input int v, input bit check);
        logic [SRAM_ADDR_WIDTH-1:0] a;
        logic [RGB_WIDTH-1:0]       r;
        @(posedge i_clk);
        #1;
        if (chk1) check_addr("o_sram_addr", exp_addr1, o_sram_addr);
        if (chk2) check_rgb("o_rgb", exp_rgb2, o_rgb);
        chk2     = chk1;
        exp_rgb2 = exp_rgb1;
        i_vga_h  = h[MAP_H_WIDTH-1:0];
        i_vga_v  = v[MAP_V_WIDTH-1:0];
        predict(h, v, a, r);
        chk1      = check;
        exp_addr1 = a;
        exp_rgb1  = r;
    endtask

    task automatic flush();
        scan_pixel(0, 0, 1'b0);
        scan_pixel(0, 0, 1'b0);
    endtask

    task automatic sweep(input int h0, input int v0, input int w, input int ht);
        for (int v = v0; v < v0 + ht; v++) begin
            for (int h = h0; h < h0 + w; h++) begin
                scan_pixel(h, v, 1'b1);
            end
        end
        flush();
    endtask

    task automatic write_palette(input int idx, input logic [RGB_WIDTH-1:0] rgb);
        @(posedge i_clk);
        #1;
        i_pal_we   = 1'b1;
        i_pal_addr = idx[COLOR_WIDTH-1:0];
        i_pal_data = rgb;
        @(posedge i_clk);
        #1;
        i_pal_we       = 1'b0;
        pal_model[idx] = rgb;
    endtask

    task automatic load_random_palette();
        for (int i = 0; i < PALETTE_DEPTH; i++) begin
            rng_state = xorshift32(rng_state);
            write_palette(i, rng_state[RGB_WIDTH-1:0]);
        end
    endtask

    task automatic place_player1(input int x, input int y);
        i_player1_x = x[MAP_H_WIDTH-1:0];
        i_player1_y = y[MAP_V_WIDTH-1:0];
    endtask

    task automatic place_player2(input int x, input int y);
        i_player2_x = x[MAP_H_WIDTH-1:0];
        i_player2_y = y[MAP_V_WIDTH-1:0];
    endtask

    task automatic place_bullets(input int x1, input int y1, input bit val1,
                                 input int x2, input int y2, input bit val2);
        i_bullet1_x     = x1[MAP_H_WIDTH-1:0];
        i_bullet1_y     = y1[MAP_V_WIDTH-1:0];
        i_bullet1_valid = val1;
        i_bullet2_x     = x2[MAP_H_WIDTH-1:0];
        i_bullet2_y     = y2[MAP_V_WIDTH-1:0];
        i_bullet2_valid = val2;
    endtask

    task automatic test_map_only();
        i_is_gaming = 1'b0;
        place_player1(100, 100);
        place_player2(108, 104);
        place_bullets(104, 104, 1'b1, 110, 110, 1'b1);
        sweep(96, 96, 24, 24);
    endtask

    task automatic test_player_mask();
        i_is_gaming = 1'b1;
        for (int i = 0; i < PLAYER_MASK_WIDTH; i++) begin
            i_player1_opacity_mask[i] = ((i / PLAYER_SIZE + i % PLAYER_SIZE) % 2) == 0;
        end
        place_player1(200, 150);
        place_player2(400, 300);
        place_bullets(0, 0, 1'b0, 0, 0, 1'b0);
        sweep(196, 148, 24, 20);
    endtask

    task automatic test_priority();
        i_player1_opacity_mask = '1;
        i_player2_opacity_mask = '1;
        i_bullet1_opacity_mask = 16'hFFFF;
        i_bullet2_opacity_mask = 16'hA5A5;
        place_player1(300, 200);
        place_player2(304, 204);
        place_bullets(306, 206, 1'b1, 308, 208, 1'b1);
        sweep(300, 200, 24, 24);
        i_bullet1_valid = 1'b0; // bullet 2 now shows through
        sweep(300, 200, 24, 24);
    endtask

    task automatic test_nibbles();
        place_player1(40, 40);
        place_bullets(60, 40, 1'b1, 500, 400, 1'b0);
        sweep(40, 40, 16, 1);
        sweep(60, 40, 4, 4);
    endtask

    task automatic test_palette_shield();
        load_random_palette();
        place_player1(120, 80);
        place_player2(128, 88);
        place_bullets(126, 86, 1'b1, 0, 0, 1'b0);
        i_player1_shield = 1'b1;
        sweep(118, 78, 28, 28);
        write_palette(3, 24'hFFFFFF);
        i_player1_shield = 1'b0;
        i_player2_shield = 1'b1;
        sweep(118, 78, 28, 28);
        i_player2_shield = 1'b0;
    endtask

    task automatic test_edges();
        place_player1(-5, -3);
        place_player2(-12, 470);
        place_bullets(-2, 10, 1'b1, 0, 0, 1'b0);
        sweep(0, 0, 16, 16);
        sweep(0, 466, 8, 14);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the tests did not complete in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        i_rst_n = 1'b1;
        i_vga_h = '0;
        i_vga_v = '0;
        i_is_gaming = 1'b0;
        i_player1_x = '0;
        i_player1_y = '0;
        i_player2_x = '0;
        i_player2_y = '0;
        i_player1_shield = 1'b0;
        i_player2_shield = 1'b0;
        i_player1_opacity_mask = '1;
        i_player2_opacity_mask = '1;
        i_bullet1_opacity_mask = '1;
        i_bullet2_opacity_mask = '1;
        place_bullets(0, 0, 1'b0, 0, 0, 1'b0);
        i_pal_we = 1'b0;
        i_pal_addr = '0;
        i_pal_data = '0;
        sram_data <= '0;
        error_count = 0;
        chk1 = 1'b0;
        chk2 = 1'b0;
        rng_state = SEED;
        for (int a = 0; a < SRAM_DEPTH; a++) begin
            rng_state   = xorshift32(rng_state);
            sram_mem[a] = rng_state[15:0] ^ 16'(a);
        end
        for (int i = 0; i < PALETTE_DEPTH; i++) pal_model[i] = '0;
        #1 i_rst_n = 1'b0;
        repeat (4) @(posedge i_clk);
        #1;
        check_addr("o_sram_addr", MAP_BASE, o_sram_addr);
        i_rst_n = 1'b1;
        sweep(0, 0, 8, 1); // palette still cleared by reset
        load_random_palette();

        test_map_only();
        test_player_mask();
        test_priority();
        test_nibbles();
        test_palette_shield();
        test_edges();

        $display("tests done, sram latency %0d, errors %0d", SRAM_LATENCY, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
render_pkg.sv
pixel_decoder.sv
sram_addr_encoder.sv
sram_data_decoder.sv
palette_regs.sv
color_decoder.sv
frame_decoder.sv
frame_decoder_sva.sv
tb_frame_decoder.sv

//--- run_sim.sh
#!/bin/bash
# build with Verilator, run, then judge the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_frame_decoder \
    -f project.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; } \
    || grep -q "SIMULATION PASSED" sim.log \
    || { echo "run ended without a result"; exit 1; }
exit 0
